// File: core_shell.sv
// Uncore shell around the integer core: sleep control and clock gate,
// register file, scramble key manager and the two-way instruction cache RAMs.
// Only the register file runs on the gated clock.
`timescale 1ns/1ps
`default_nettype none

module core_shell import shell_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       test_en_i,

  // Sleep and wake
  input  logic                       core_busy_i,
  input  logic                       irq_pending_i,
  input  logic                       irq_nm_i,
  input  logic                       debug_req_i,
  output logic                       core_sleep_o,

  // Register file
  input  reg_addr_t                  rf_raddr_a_i,
  input  reg_addr_t                  rf_raddr_b_i,
  output reg_data_t                  rf_rdata_a_o,
  output reg_data_t                  rf_rdata_b_o,
  input  rf_wr_t                     rf_wr_i,

  // Instruction cache RAMs
  input  ic_tag_req_t                ic_tag_req_i,
  input  ic_data_req_t               ic_data_req_i,
  output ic_tag_t  [IcNumWays-1:0]   ic_tag_rdata_o,
  output ic_line_t [IcNumWays-1:0]   ic_data_rdata_o,

  // Scramble key
  input  logic                       ic_scr_key_req_i,
  input  logic                       scramble_key_valid_i,
  input  scr_key_t                   scramble_key_i,
  output logic                       scramble_req_o,
  output logic                       ic_scr_key_valid_o,
  output scr_key_t                   scr_key_o
);

  logic clk_core;

  //////////////////////////////////////////////////////////////////////
  // Clock gate and sleep
  //////////////////////////////////////////////////////////////////////

  sleep_ctrl u_sleep_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .test_en_i     (test_en_i),
    .core_busy_i   (core_busy_i),
    .irq_pending_i (irq_pending_i),
    .irq_nm_i      (irq_nm_i),
    .debug_req_i   (debug_req_i),
    .clk_gated_o   (clk_core),
    .core_sleep_o  (core_sleep_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  regfile_ff u_regfile (
    .clk_i     (clk_core),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a_i),
    .raddr_b_i (rf_raddr_b_i),
    .rdata_a_o (rf_rdata_a_o),
    .rdata_b_o (rf_rdata_b_o),
    .wr_i      (rf_wr_i)
  );

  //////////////////////////////////////////////////////////////////////
  // Scramble key manager
  //////////////////////////////////////////////////////////////////////

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .key_req_i      (ic_scr_key_req_i),
    .key_valid_i    (scramble_key_valid_i),
    .key_i          (scramble_key_i),
    .key_o          (scr_key_o),
    .key_valid_o    (ic_scr_key_valid_o),
    .scramble_req_o (scramble_req_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Cache RAMs
  //////////////////////////////////////////////////////////////////////

  // Shared write, address and data; each way sees its own request bit
  for (genvar w = 0; w < IcNumWays; w++) begin : gen_way
    icache_ram_bank #(
      .Width (IcTagW),
      .Depth (IcNumLines)
    ) u_tag_bank (
      .clk_i   (clk_i),
      .req_i   (ic_tag_req_i.req[w]),
      .write_i (ic_tag_req_i.write),
      .addr_i  (ic_tag_req_i.addr),
      .wdata_i (ic_tag_req_i.wdata),
      .rdata_o (ic_tag_rdata_o[w])
    );

    icache_ram_bank #(
      .Width (IcLineW),
      .Depth (IcNumLines)
    ) u_data_bank (
      .clk_i   (clk_i),
      .req_i   (ic_data_req_i.req[w]),
      .write_i (ic_data_req_i.write),
      .addr_i  (ic_data_req_i.addr),
      .wdata_i (ic_data_req_i.wdata),
      .rdata_o (ic_data_rdata_o[w])
    );
  end

endmodule

`default_nettype wire

// File: filelist.f
shell_pkg.sv
sleep_ctrl.sv
regfile_ff.sv
scramble_key_ctrl.sv
icache_ram_bank.sv
core_shell.sv
tb_core_shell.sv

// File: icache_ram_bank.sv
// Single-port synchronous RAM with registered read, one cycle latency.
// Read data holds until the next read request; a write does not update it.
// Depth must not exceed the range of ic_index_t.
`timescale 1ns/1ps
`default_nettype none

module icache_ram_bank import shell_pkg::*; #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 16
) (
  input  logic             clk_i,
  input  logic             req_i,
  input  logic             write_i,
  input  ic_index_t        addr_i,
  input  logic [Width-1:0] wdata_i,
  output logic [Width-1:0] rdata_o
);

  logic [Width-1:0] mem [Depth];
  logic [Width-1:0] rdata_q;

  //////////////////////////////////////////////////////////////////////
  // Array access
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

  // The cache controller must present a valid index with every access
  addr_known_a: assert property (
    @(posedge clk_i) req_i |-> !$isunknown(addr_i)
  ) else $error("RAM address unknown during request");

endmodule

`default_nettype wire

// File: regfile_ff.sv
// Flip-flop register file, two combinational read ports and one write port.
// Index 0 reads zero and ignores writes. Runs on the gated core clock.
`timescale 1ns/1ps
`default_nettype none

module regfile_ff import shell_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output reg_data_t rdata_a_o,
  output reg_data_t rdata_b_o,
  input  rf_wr_t    wr_i
);

  reg_data_t                rf_q [NumRegs];
  logic [NumRegs-1:1]       we_dec;

  //////////////////////////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////////////////////////

  // One-hot enable, x0 has no bit
  always_comb begin
    for (int unsigned i = 1; i < NumRegs; i++) begin
      we_dec[i] = wr_i.we && (wr_i.waddr == reg_addr_t'(i));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 1; i < NumRegs; i++) begin : gen_regs
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_q[i] <= '0;
      end else if (we_dec[i]) begin
        rf_q[i] <= wr_i.wdata;
      end
    end
  end

  // Hard-wired zero
  assign rf_q[0] = '0;

  // Reads
  assign rdata_a_o = rf_q[raddr_a_i];
  assign rdata_b_o = rf_q[raddr_b_i];

  // A write to x1..x31 lands in the addressed entry at the next edge
  write_store_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (wr_i.we && (wr_i.waddr != '0)) |=> (rf_q[$past(wr_i.waddr)] == $past(wr_i.wdata))
  ) else $error("register write was not stored");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core shell testbench with Verilator.
# Exits non-zero when the build, the run or any test fails.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_core_shell \
  --Mdir "$BUILD_DIR" \
  -o tb_core_shell
if [ $? -ne 0 ]; then
  echo "run_sim: Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_core_shell" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "run_sim: simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG_FILE"; then
  echo "run_sim: failures reported, see $LOG_FILE"
  exit 1
fi

echo "run_sim: no failures reported"
exit 0

// File: scramble_key_ctrl.sv
// Instruction-cache scramble key manager.
// A request pulse invalidates the key and asks the provider for a new one;
// the request level holds until the provider returns valid. No back-pressure.
`timescale 1ns/1ps
`default_nettype none

module scramble_key_ctrl import shell_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     key_req_i,
  input  logic     key_valid_i,
  input  scr_key_t key_i,
  output scr_key_t key_o,
  output logic     key_valid_o,
  output logic     scramble_req_o
);

  scr_state_e state_q, state_d;
  logic       key_valid_q, key_valid_d;
  scr_key_t   key_q;

  //////////////////////////////////////////////////////////////////////
  // Request FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ScrIdle: begin
        if (key_req_i) begin
          state_d = ScrWaitKey;
        end
      end
      ScrWaitKey: begin
        if (key_valid_i) begin
          state_d = ScrIdle;
        end
      end
      default: state_d = ScrIdle;
    endcase
  end

  // Valid follows the provider while waiting, drops on a new request
  always_comb begin
    key_valid_d = key_valid_q;
    if (state_q == ScrWaitKey) begin
      key_valid_d = key_valid_i;
    end else if (key_req_i) begin
      key_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ScrIdle;
      key_valid_q <= 1'b1;
    end else begin
      state_q     <= state_d;
      key_valid_q <= key_valid_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Key and nonce
  //////////////////////////////////////////////////////////////////////

  // Loads whenever the provider presents a key, requested or not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q <= ScrKeyDefault;
    end else if (key_valid_i) begin
      key_q <= key_i;
    end
  end

  assign key_o          = key_q;
  assign key_valid_o    = key_valid_q;
  assign scramble_req_o = (state_q == ScrWaitKey);

  // No valid key is reported while a new one is requested
  key_invalid_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    scramble_req_o |-> !key_valid_o
  ) else $error("key_valid_o high while scramble_req_o is pending");

endmodule

`default_nettype wire

// File: shell_pkg.sv
// Shared widths, types and reset constants of the core shell.
// Cache geometry is fixed at two ways of sixteen 64-bit lines.
`default_nettype none

package shell_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NumRegs  = 32;
  localparam int unsigned RegAddrW = $clog2(NumRegs);
  localparam int unsigned RegDataW = 32;

  typedef logic [RegAddrW-1:0] reg_addr_t;
  typedef logic [RegDataW-1:0] reg_data_t;

  // Write port, 38 bits
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    reg_data_t wdata;
  } rf_wr_t;

  //////////////////////////////////////////////////////////////////////
  // Instruction cache RAMs
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned IcNumWays  = 2;
  localparam int unsigned IcNumLines = 16;
  localparam int unsigned IcIndexW   = $clog2(IcNumLines);
  // Valid bit plus 21 tag bits
  localparam int unsigned IcTagW     = 22;
  // Two 32-bit bus beats per line
  localparam int unsigned IcLineW    = 64;

  typedef logic [IcIndexW-1:0]  ic_index_t;
  typedef logic [IcTagW-1:0]    ic_tag_t;
  typedef logic [IcLineW-1:0]   ic_line_t;
  typedef logic [IcNumWays-1:0] ic_way_mask_t;

  typedef struct packed {
    ic_way_mask_t req;
    logic         write;
    ic_index_t    addr;
    ic_tag_t      wdata;
  } ic_tag_req_t;

  typedef struct packed {
    ic_way_mask_t req;
    logic         write;
    ic_index_t    addr;
    ic_line_t     wdata;
  } ic_data_req_t;

  //////////////////////////////////////////////////////////////////////
  // Scramble key
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ScrKeyW   = 128;
  localparam int unsigned ScrNonceW = 64;

  typedef struct packed {
    logic [ScrKeyW-1:0]   key;
    logic [ScrNonceW-1:0] nonce;
  } scr_key_t;

  localparam scr_key_t ScrKeyDefault = '{
    key:   128'h3c1f_9a27_e4b0_5d86_71c2_0fa9_b83e_6d54,
    nonce: 64'hd2a4_17f0_8c63_5eb9
  };

  typedef enum logic {
    ScrIdle,
    ScrWaitKey
  } scr_state_e;

endpackage

`default_nettype wire

// File: sleep_ctrl.sv
// Sleep and clock-enable control for the core clock domain.
// core_busy_i is registered, the other wake sources act in the same cycle.
// The clock gate is a behavioural latch plus AND; swap in a library cell for synthesis.
`timescale 1ns/1ps
`default_nettype none

module sleep_ctrl (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic test_en_i,
  input  logic core_busy_i,
  input  logic irq_pending_i,
  input  logic irq_nm_i,
  input  logic debug_req_i,
  output logic clk_gated_o,
  output logic core_sleep_o
);

  logic core_busy_q;
  logic wake;
  logic clk_en;
  logic clk_en_latch;

  //////////////////////////////////////////////////////////////////////
  // Wake condition
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  assign wake         = core_busy_q | irq_pending_i | debug_req_i | irq_nm_i;
  assign core_sleep_o = ~wake;

  //////////////////////////////////////////////////////////////////////
  // Clock gate
  //////////////////////////////////////////////////////////////////////

  // Test mode keeps the gate open
  assign clk_en = wake | test_en_i;

  // Transparent while clk_i is low, so the enable is stable during the high phase
  always_latch begin
    if (!clk_i) begin
      clk_en_latch <= clk_en;
    end
  end

  assign clk_gated_o = clk_i & clk_en_latch;

  // Sleep output must resolve once out of reset
  sleep_known_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown(core_sleep_o)
  ) else $error("core_sleep_o is unknown");

endmodule

`default_nettype wire

// File: tb_core_shell.sv
// Directed testbench for the core shell. It plays the core, the cache controller
// and the key provider. Inputs change on the rising edge and outputs are sampled
// on the falling edge. A cycle limit ends a run that hangs.
`timescale 1ns/1ps
`default_nettype none

module tb_core_shell import shell_pkg::*; ();

  // Tests take under 100 cycles together, the limit leaves a wide margin
  localparam int unsigned TimeoutCycles = 2000;
  localparam int unsigned NumWrites     = 6;

  typedef logic [191:0] cmp_t;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         test_en;
  logic         core_busy;
  logic         irq_pending;
  logic         irq_nm;
  logic         debug_req;
  logic         core_sleep;
  reg_addr_t    rf_raddr_a;
  reg_addr_t    rf_raddr_b;
  reg_data_t    rf_rdata_a;
  reg_data_t    rf_rdata_b;
  rf_wr_t       rf_wr;
  ic_tag_req_t  ic_tag_req;
  ic_data_req_t ic_data_req;
  ic_tag_t  [IcNumWays-1:0] ic_tag_rdata;
  ic_line_t [IcNumWays-1:0] ic_data_rdata;
  logic         ic_scr_key_req;
  logic         scramble_key_valid;
  scr_key_t     scramble_key;
  logic         scramble_req;
  logic         ic_scr_key_valid;
  scr_key_t     scr_key;

  integer       seed = 32'h6a15_55d4;
  int unsigned  err_count = 0;
  int unsigned  test_count = 0;
  int unsigned  failed_tests = 0;
  int unsigned  cycle_count = 0;
  reg_data_t    rf_model [NumRegs];

  core_shell core_shell_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .test_en_i            (test_en),
    .core_busy_i          (core_busy),
    .irq_pending_i        (irq_pending),
    .irq_nm_i             (irq_nm),
    .debug_req_i          (debug_req),
    .core_sleep_o         (core_sleep),
    .rf_raddr_a_i         (rf_raddr_a),
    .rf_raddr_b_i         (rf_raddr_b),
    .rf_rdata_a_o         (rf_rdata_a),
    .rf_rdata_b_o         (rf_rdata_b),
    .rf_wr_i              (rf_wr),
    .ic_tag_req_i         (ic_tag_req),
    .ic_data_req_i        (ic_data_req),
    .ic_tag_rdata_o       (ic_tag_rdata),
    .ic_data_rdata_o      (ic_data_rdata),
    .ic_scr_key_req_i     (ic_scr_key_req),
    .scramble_key_valid_i (scramble_key_valid),
    .scramble_key_i       (scramble_key),
    .scramble_req_o       (scramble_req),
    .ic_scr_key_valid_o   (ic_scr_key_valid),
    .scr_key_o            (scr_key)
  );

  always #20 clk_i = ~clk_i;

  // Run limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  task automatic compare_value(input string name, input cmp_t expected, input cmp_t actual);
    if (actual !== expected) begin
      $display("mismatch in %s: expected %h, actual %h", name, expected, actual);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int unsigned errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: failed with %0d mismatches", name, err_count - errs_before);
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(posedge clk_i);
    rf_wr <= '{we: 1'b1, waddr: addr, wdata: data};
    @(posedge clk_i);
    rf_wr <= '{we: 1'b0, waddr: '0, wdata: '0};
  endtask

  task automatic read_both(input string name, input reg_addr_t addr_a, input reg_addr_t addr_b);
    @(posedge clk_i);
    rf_raddr_a <= addr_a;
    rf_raddr_b <= addr_b;
    @(negedge clk_i);
    compare_value({name, " port a"}, cmp_t'(rf_model[addr_a]), cmp_t'(rf_rdata_a));
    compare_value({name, " port b"}, cmp_t'(rf_model[addr_b]), cmp_t'(rf_rdata_b));
  endtask

  task automatic wait_for_sleep();
    @(negedge clk_i);
    while (core_sleep !== 1'b1) begin
      @(negedge clk_i);
    end
  endtask

  // Order is debug request, NMI, pending interrupt
  task automatic drive_wake(input logic [2:0] sel);
    {debug_req, irq_nm, irq_pending} <= sel;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    int unsigned errs;
    errs = err_count;
    @(negedge clk_i);
    compare_value("reset sleep", cmp_t'(1'b1), cmp_t'(core_sleep));
    compare_value("reset scramble_req", cmp_t'(1'b0), cmp_t'(scramble_req));
    compare_value("reset key valid", cmp_t'(1'b1), cmp_t'(ic_scr_key_valid));
    compare_value("reset key", cmp_t'(ScrKeyDefault), cmp_t'(scr_key));
    report_test("reset_state", errs);
  endtask

  task automatic wake_sources();
    int unsigned errs;
    errs = err_count;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk_i);
      drive_wake(3'b100 >> i);
      @(negedge clk_i);
      compare_value("direct wake", cmp_t'(1'b0), cmp_t'(core_sleep));
      @(posedge clk_i);
      drive_wake(3'b000);
      @(negedge clk_i);
      compare_value("direct wake released", cmp_t'(1'b1), cmp_t'(core_sleep));
    end
    // Busy goes through a register, one cycle late
    @(posedge clk_i);
    core_busy <= 1'b1;
    @(negedge clk_i);
    compare_value("busy same cycle", cmp_t'(1'b1), cmp_t'(core_sleep));
    @(negedge clk_i);
    compare_value("busy next cycle", cmp_t'(1'b0), cmp_t'(core_sleep));
    @(posedge clk_i);
    core_busy <= 1'b0;
    @(negedge clk_i);
    compare_value("busy drop same cycle", cmp_t'(1'b0), cmp_t'(core_sleep));
    @(negedge clk_i);
    compare_value("busy drop next cycle", cmp_t'(1'b1), cmp_t'(core_sleep));
    report_test("wake_sources", errs);
  endtask

  task automatic regfile_access();
    int unsigned errs;
    reg_addr_t   idx_list [NumWrites];
    reg_addr_t   idx;
    reg_data_t   data;
    errs = err_count;
    @(posedge clk_i);
    core_busy <= 1'b1;
    @(negedge clk_i);
    while (core_sleep !== 1'b0) begin
      @(negedge clk_i);
    end
    for (int unsigned i = 0; i < NumWrites; i++) begin
      idx = reg_addr_t'(next_rand());
      if (idx == '0) begin
        idx = reg_addr_t'(i + 1);
      end
      data = next_rand();
      idx_list[i] = idx;
      rf_model[idx] = data;
      write_reg(idx, data);
    end
    for (int unsigned i = 0; i < NumWrites; i++) begin
      read_both("regfile readback", idx_list[i], idx_list[(i + 1) % NumWrites]);
    end
    // x0 stays zero in the model as well
    write_reg('0, next_rand());
    read_both("regfile x0", '0, '0);
    // Gated clock stopped, the write must be lost
    @(posedge clk_i);
    core_busy <= 1'b0;
    wait_for_sleep();
    write_reg(idx_list[0], next_rand());
    read_both("regfile write asleep", idx_list[0], idx_list[1]);
    report_test("regfile_access", errs);
  endtask

  task automatic key_refresh();
    int unsigned errs;
    int unsigned wait_len;
    scr_key_t    new_key;
    errs = err_count;
    new_key  = {next_rand(), next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
    wait_len = (next_rand() & 32'd7) + 1;
    @(posedge clk_i);
    ic_scr_key_req <= 1'b1;
    @(posedge clk_i);
    ic_scr_key_req <= 1'b0;
    @(negedge clk_i);
    compare_value("key request raised", cmp_t'(1'b1), cmp_t'(scramble_req));
    compare_value("key invalidated", cmp_t'(1'b0), cmp_t'(ic_scr_key_valid));
    for (int unsigned i = 0; i < wait_len; i++) begin
      @(negedge clk_i);
      compare_value("key request held", cmp_t'(1'b1), cmp_t'(scramble_req));
      compare_value("key still invalid", cmp_t'(1'b0), cmp_t'(ic_scr_key_valid));
    end
    @(posedge clk_i);
    scramble_key_valid <= 1'b1;
    scramble_key       <= new_key;
    @(posedge clk_i);
    scramble_key_valid <= 1'b0;
    @(negedge clk_i);
    compare_value("key request done", cmp_t'(1'b0), cmp_t'(scramble_req));
    compare_value("key valid again", cmp_t'(1'b1), cmp_t'(ic_scr_key_valid));
    compare_value("new key", cmp_t'(new_key), cmp_t'(scr_key));
    report_test("key_refresh", errs);
  endtask

  task automatic cache_rams();
    int unsigned errs;
    ic_index_t   idx;
    ic_tag_t     tag [IcNumWays];
    ic_line_t    line [IcNumWays];
    errs = err_count;
    idx = ic_index_t'(next_rand());
    for (int w = 0; w < IcNumWays; w++) begin
      tag[w]  = ic_tag_t'(next_rand());
      line[w] = {next_rand(), next_rand()};
    end
    // Distinct contents per way
    tag[1]  = (tag[1] == tag[0]) ? ~tag[0] : tag[1];
    line[1] = (line[1] == line[0]) ? ~line[0] : line[1];
    for (int w = 0; w < IcNumWays; w++) begin
      @(posedge clk_i);
      ic_tag_req  <= '{req: ic_way_mask_t'(1 << w), write: 1'b1, addr: idx, wdata: tag[w]};
      ic_data_req <= '{req: ic_way_mask_t'(1 << w), write: 1'b1, addr: idx, wdata: line[w]};
    end
    for (int w = 0; w < IcNumWays; w++) begin
      @(posedge clk_i);
      ic_tag_req  <= '{req: ic_way_mask_t'(1 << w), write: 1'b0, addr: idx, wdata: '0};
      ic_data_req <= '{req: ic_way_mask_t'(1 << w), write: 1'b0, addr: idx, wdata: '0};
      @(posedge clk_i);
      ic_tag_req  <= '{req: '0, write: 1'b0, addr: '0, wdata: '0};
      ic_data_req <= '{req: '0, write: 1'b0, addr: '0, wdata: '0};
      @(negedge clk_i);
      compare_value("tag read", cmp_t'(tag[w]), cmp_t'(ic_tag_rdata[w]));
      compare_value("line read", cmp_t'(line[w]), cmp_t'(ic_data_rdata[w]));
    end
    // Way 0 was idle during the way 1 read
    compare_value("tag hold", cmp_t'(tag[0]), cmp_t'(ic_tag_rdata[0]));
    compare_value("line hold", cmp_t'(line[0]), cmp_t'(ic_data_rdata[0]));
    report_test("cache_rams", errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni             = 1'b0;
    test_en            = 1'b0;
    core_busy          = 1'b0;
    irq_pending        = 1'b0;
    irq_nm             = 1'b0;
    debug_req          = 1'b0;
    rf_raddr_a         = '0;
    rf_raddr_b         = '0;
    rf_wr              = '0;
    ic_tag_req         = '0;
    ic_data_req        = '0;
    ic_scr_key_req     = 1'b0;
    scramble_key_valid = 1'b0;
    scramble_key       = '0;
    for (int i = 0; i < NumRegs; i++) begin
      rf_model[i] = '0;
    end
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    reset_state();
    wake_sources();
    regfile_access();
    key_refresh();
    cache_rams();

    $display("%0d tests run, %0d failed, %0d mismatches", test_count, failed_tests, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
